// ==== rtl/dptx_pkg.sv ====
`default_nettype none

package dptx_pkg;

    // Lane symbol, bit 8 is the K flag
    typedef logic [8:0]  sym_t;
    typedef logic [23:0] pix_t;      // R in 23:16, G in 15:8, B in 7:0
    typedef logic [7:0]  msg_id_t;
    typedef logic [15:0] msg_dat_t;
    typedef logic [1:0]  tps_t;

    // Link generator states
    typedef enum logic [2:0]
    {
        st_off,
        st_tps1,
        st_tps2,
        st_blank,
        st_line
    } lnk_state_t;

    // Training pattern select
    localparam tps_t TPS_NONE = 2'd0;
    localparam tps_t TPS_1    = 2'd1;
    localparam tps_t TPS_2    = 2'd2;   // Value 3 reserved

    // Control symbols
    localparam sym_t SYM_BE    = 9'h1FB;   // K27.7
    localparam sym_t SYM_BS    = 9'h1BC;   // K28.5
    localparam sym_t SYM_FILL  = 9'h11C;   // K28.0

    // Training symbols
    localparam sym_t SYM_D10_2 = 9'h04A;
    localparam sym_t SYM_K28_5 = 9'h1BC;
    localparam sym_t SYM_D11_6 = 9'h0CB;

    // Message identifiers
    localparam msg_id_t MSG_ID_CTL = 8'h10;   // Bit 0 lnk_en, bit 1 vid_en
    localparam msg_id_t MSG_ID_TPS = 8'h11;   // Bits 1:0 pattern

endpackage

`default_nettype wire

// ==== rtl/dptx_vid_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Sampled pixels toward the packer, no back-pressure
interface dptx_vid_if;

    logic           vld;    // One strobe per active pixel
    logic           sol;    // First pixel of line
    logic           eol;    // Last pixel of line
    dptx_pkg::pix_t pix;

    // Video input stage
    modport drv (output vld, sol, eol, pix);

    // Packer
    modport rcv (input vld, sol, eol, pix);

endinterface

`default_nettype wire

// ==== rtl/dptx_word_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Packed lane words, valid/ready
interface dptx_word_if
#(
    parameter int P_LANES = 4
);

    logic                           vld;
    logic                           rdy;
    logic                           first;  // First word of line
    logic                           last;   // Last word of line
    dptx_pkg::sym_t [P_LANES-1:0]   dat;    // Lane 0 in low bits

    modport drv (output vld, first, last, dat, input rdy);
    modport rcv (input vld, first, last, dat, output rdy);

endinterface

`default_nettype wire

// ==== rtl/dptx_msg_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module dptx_msg_rx
(
    input wire                  sys_clk,
    input wire                  arst_n,

    // Host message port, four-phase
    input wire                  msg_req,
    input wire dptx_pkg::msg_id_t   msg_id,
    input wire dptx_pkg::msg_dat_t  msg_dat,
    output logic                msg_ack,
    output logic                msg_err,

    // Control registers
    output logic                lnk_en,
    output logic                vid_en,
    output dptx_pkg::tps_t      tps
);

logic req_s;        // Sampled request
logic ack_set;
logic ack_clr;

// msg_ack doubles as the phase flag
assign ack_set = req_s && !msg_ack;     // Request seen, not yet answered
assign ack_clr = !req_s && msg_ack;     // Host released

// Handshake
always_ff @(posedge sys_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        req_s   <= 1'b0;
        msg_ack <= 1'b0;
        msg_err <= 1'b0;
    end
    else
    begin
        req_s <= msg_req;

        if (ack_set)
        begin
            msg_ack <= 1'b1;
            // Unknown id flagged together with ack
            msg_err <= (msg_id != dptx_pkg::MSG_ID_CTL) && (msg_id != dptx_pkg::MSG_ID_TPS);
        end
        else if (ack_clr)
        begin
            msg_ack <= 1'b0;
            msg_err <= 1'b0;
        end
    end
end

// Control registers, written on the ack edge
always_ff @(posedge sys_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        lnk_en <= 1'b0;
        vid_en <= 1'b0;
        tps    <= dptx_pkg::TPS_NONE;
    end
    else if (ack_set)
    begin
        case (msg_id)
            dptx_pkg::MSG_ID_CTL:
            begin
                lnk_en <= msg_dat[0];
                vid_en <= msg_dat[1];
            end

            dptx_pkg::MSG_ID_TPS:
                tps <= dptx_pkg::tps_t'(msg_dat[1:0]);

            default: ;  // Nothing changes
        endcase
    end
end

endmodule

`default_nettype wire

// ==== rtl/dptx_vid_in.sv ====
`default_nettype none
`timescale 1ns/1ps

module dptx_vid_in
(
    input wire          sys_clk,
    input wire          arst_n,

    // Video input
    input wire          vid_cke,
    input wire          vid_de,
    input wire [7:0]    vid_r,
    input wire [7:0]    vid_g,
    input wire [7:0]    vid_b,

    dptx_vid_if.drv     vid
);

// One pixel is held back until the next sample shows whether de dropped
dptx_pkg::pix_t hold_pix;
logic           hold_sol;   // Held pixel opens a line
logic           de_prev;    // Previous de, also marks hold_pix valid

always_ff @(posedge sys_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        de_prev  <= 1'b0;
        hold_sol <= 1'b0;
        vid.vld  <= 1'b0;
    end
    else
    begin
        vid.vld <= vid_cke && de_prev;      // Release held pixel
        if (vid_cke)
        begin
            de_prev  <= vid_de;
            hold_sol <= vid_de && !de_prev;  // Rising de
        end
    end
end

// Payload
always_ff @(posedge sys_clk)
begin
    if (vid_cke)
    begin
        hold_pix <= {vid_r, vid_g, vid_b};
        vid.pix  <= hold_pix;
        vid.sol  <= hold_sol;
        vid.eol  <= !vid_de;    // de fell after the held pixel
    end
end

endmodule

`default_nettype wire

// ==== rtl/dptx_packer.sv ====
`default_nettype none
`timescale 1ns/1ps

module dptx_packer
#(
    parameter int P_LANES = 4
)
(
    input wire          sys_clk,
    input wire          arst_n,

    dptx_vid_if.rcv     vid,
    dptx_word_if.drv    word,

    output logic        ovf     // Sticky
);

localparam int P_DEPTH = 2 * P_LANES + 3;      // Byte slots
localparam int P_CW    = $clog2(P_DEPTH + 1);

// Byte buffer, head at index 0
logic [7:0]         mem_dat [0:P_DEPTH-1];
logic [P_DEPTH-1:0] mem_sol;    // Byte opens a line
logic [P_DEPTH-1:0] mem_eol;    // Byte closes a line
logic [P_CW-1:0]    cnt;

logic [7:0]         nxt_dat [0:P_DEPTH-1];
logic [P_DEPTH-1:0] nxt_sol;
logic [P_DEPTH-1:0] nxt_eol;
logic [P_CW-1:0]    nxt_cnt;

logic [P_CW-1:0]    take;       // Bytes in the next word
logic               found;      // Line end inside the next word
logic               space;
logic               push;
logic               pop;

// Word size, stops after a line end
always_comb
begin
    take  = '0;
    found = 1'b0;
    for (int i = 0; i < P_LANES; i++)
    begin
        if (!found && (i < int'(cnt)))
        begin
            take  = P_CW'(i + 1);
            found = mem_eol[i];
        end
    end
end

assign space = (int'(cnt) <= P_DEPTH - 3);     // Room for R, G, B
assign push  = vid.vld && space;
assign pop   = (found || (int'(take) == P_LANES)) && (!word.vld || word.rdy);

// Buffer update, pop then append
always_comb
begin
    nxt_sol = mem_sol;
    nxt_eol = mem_eol;
    nxt_cnt = cnt;
    for (int i = 0; i < P_DEPTH; i++)
        nxt_dat[i] = mem_dat[i];

    if (pop)
    begin
        for (int i = 0; i < P_DEPTH; i++)
        begin
            if (i + int'(take) < P_DEPTH)
            begin
                nxt_dat[i] = mem_dat[i + int'(take)];
                nxt_sol[i] = mem_sol[i + int'(take)];
                nxt_eol[i] = mem_eol[i + int'(take)];
            end
        end
        nxt_cnt = cnt - take;
    end

    if (push)
    begin
        nxt_dat[nxt_cnt]           = vid.pix[23:16];   // R
        nxt_dat[nxt_cnt + P_CW'(1)] = vid.pix[15:8];   // G
        nxt_dat[nxt_cnt + P_CW'(2)] = vid.pix[7:0];    // B
        nxt_sol[nxt_cnt]           = vid.sol;
        nxt_sol[nxt_cnt + P_CW'(1)] = 1'b0;
        nxt_sol[nxt_cnt + P_CW'(2)] = 1'b0;
        nxt_eol[nxt_cnt]           = 1'b0;
        nxt_eol[nxt_cnt + P_CW'(1)] = 1'b0;
        nxt_eol[nxt_cnt + P_CW'(2)] = vid.eol;
        nxt_cnt                    = nxt_cnt + P_CW'(3);
    end
end

always_ff @(posedge sys_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        cnt      <= '0;
        ovf      <= 1'b0;
        word.vld <= 1'b0;
    end
    else
    begin
        cnt <= nxt_cnt;
        if (vid.vld && !space)
            ovf <= 1'b1;    // Pixel dropped

        if (pop)
            word.vld <= 1'b1;
        else if (word.rdy)
            word.vld <= 1'b0;
    end
end

// Buffer and word payload
always_ff @(posedge sys_clk)
begin
    mem_dat <= nxt_dat;
    mem_sol <= nxt_sol;
    mem_eol <= nxt_eol;

    if (pop)
    begin
        word.first <= mem_sol[0];
        word.last  <= found;
        for (int l = 0; l < P_LANES; l++)
            word.dat[l] <= (l < int'(take)) ? dptx_pkg::sym_t'({1'b0, mem_dat[l]}) : '0;
    end
end

endmodule

`default_nettype wire

// ==== rtl/dptx_lnk_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module dptx_lnk_gen
#(
    parameter int P_LANES = 4
)
(
    input wire                          sys_clk,
    input wire                          arst_n,

    // Control
    input wire                          lnk_en,
    input wire                          vid_en,
    input wire dptx_pkg::tps_t          tps,

    dptx_word_if.rcv                    word,

    output dptx_pkg::sym_t [P_LANES-1:0] lnk_dat
);

dptx_pkg::lnk_state_t           state;
dptx_pkg::lnk_state_t           nxt_state;
dptx_pkg::sym_t [P_LANES-1:0]   nxt_dat;
logic                           tps_ph;     // TPS2 phase, 0 gives K28.5
logic                           nxt_ph;
logic                           bs_pend;    // BS owed after last word
logic                           nxt_bs;

always_comb
begin
    nxt_state = dptx_pkg::st_blank;
    nxt_dat   = {P_LANES{dptx_pkg::SYM_FILL}};
    nxt_ph    = 1'b0;
    nxt_bs    = 1'b0;
    word.rdy  = 1'b1;   // Words dropped unless in video mode

    if (!lnk_en)
    begin
        nxt_state = dptx_pkg::st_off;
        nxt_dat   = '0;
    end
    // Training wins over video
    else if (tps == dptx_pkg::TPS_1)
    begin
        nxt_state = dptx_pkg::st_tps1;
        nxt_dat   = {P_LANES{dptx_pkg::SYM_D10_2}};
    end
    else if (tps == dptx_pkg::TPS_2)
    begin
        nxt_state = dptx_pkg::st_tps2;
        nxt_dat   = {P_LANES{tps_ph ? dptx_pkg::SYM_D11_6 : dptx_pkg::SYM_K28_5}};
        nxt_ph    = !tps_ph;
    end
    else if ((tps == dptx_pkg::TPS_NONE) && vid_en)
    begin
        case (state)
            dptx_pkg::st_line:
            begin
                nxt_state = dptx_pkg::st_line;
                if (word.vld)
                begin
                    nxt_dat = word.dat;     // FILL in gaps otherwise
                    if (word.last)
                    begin
                        nxt_state = dptx_pkg::st_blank;
                        nxt_bs    = 1'b1;
                    end
                end
            end

            // Blank, also entry from off or training
            default:
            begin
                word.rdy = !(word.vld && word.first);   // Hold line start for BE
                if (bs_pend)
                    nxt_dat = {P_LANES{dptx_pkg::SYM_BS}};
                else if (word.vld && word.first)
                begin
                    nxt_dat   = {P_LANES{dptx_pkg::SYM_BE}};
                    nxt_state = dptx_pkg::st_line;
                end
            end
        endcase
    end
end

always_ff @(posedge sys_clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        state   <= dptx_pkg::st_off;
        lnk_dat <= '0;
        tps_ph  <= 1'b0;
        bs_pend <= 1'b0;
    end
    else
    begin
        state   <= nxt_state;
        lnk_dat <= nxt_dat;
        tps_ph  <= nxt_ph;
        bs_pend <= nxt_bs;
    end
end

endmodule

`default_nettype wire

// ==== rtl/dptx_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module dptx_top
#(
    parameter int P_LANES = 4   // 1, 2 or 4
)
(
    input wire                              sys_clk,
    input wire                              arst_n,

    // Host messages
    input wire                              msg_req,
    input wire dptx_pkg::msg_id_t           msg_id,
    input wire dptx_pkg::msg_dat_t          msg_dat,
    output wire                             msg_ack,
    output wire                             msg_err,

    // Video
    input wire                              vid_cke,
    input wire                              vid_de,
    input wire [7:0]                        vid_r,
    input wire [7:0]                        vid_g,
    input wire [7:0]                        vid_b,

    // Link
    output wire dptx_pkg::sym_t [P_LANES-1:0] lnk_dat,
    output wire                             ovf
);

wire                    lnk_en;
wire                    vid_en;
wire dptx_pkg::tps_t    tps;

dptx_vid_if u_vid_if ();

dptx_word_if #(.P_LANES(P_LANES)) u_word_if ();

dptx_msg_rx u_msg_rx
(
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .msg_req    (msg_req),
    .msg_id     (msg_id),
    .msg_dat    (msg_dat),
    .msg_ack    (msg_ack),
    .msg_err    (msg_err),
    .lnk_en     (lnk_en),
    .vid_en     (vid_en),
    .tps        (tps)
);

dptx_vid_in u_vid_in
(
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .vid_cke    (vid_cke),
    .vid_de     (vid_de),
    .vid_r      (vid_r),
    .vid_g      (vid_g),
    .vid_b      (vid_b),
    .vid        (u_vid_if.drv)
);

dptx_packer #(.P_LANES(P_LANES)) u_packer
(
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .vid        (u_vid_if.rcv),
    .word       (u_word_if.drv),
    .ovf        (ovf)
);

dptx_lnk_gen #(.P_LANES(P_LANES)) u_lnk_gen
(
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .lnk_en     (lnk_en),
    .vid_en     (vid_en),
    .tps        (tps),
    .word       (u_word_if.rcv),
    .lnk_dat    (lnk_dat)
);

endmodule

`default_nettype wire

// ==== bench/dptx_tb_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

// Protocol checks on the host port and the packing buffer
module dptx_tb_assertions
(
    input wire  sys_clk,
    input wire  arst_n,
    input wire  msg_req,
    input wire  msg_ack,
    input wire  msg_err,
    input wire  ovf
);

// Ack only answers a request
ack_rise_needs_req: assert property (@(posedge sys_clk) disable iff (!arst_n)
    $rose(msg_ack) |-> $past(msg_req))
    else $error("msg_ack rose without msg_req");

// Ack held until host lets go
ack_fall_after_release: assert property (@(posedge sys_clk) disable iff (!arst_n)
    $fell(msg_ack) |-> !$past(msg_req))
    else $error("msg_ack fell while msg_req high");

assert property (@(posedge sys_clk) disable iff (!arst_n)
    !msg_ack |-> !msg_err)
    else $error("msg_err high without msg_ack");   // Error only with ack

// Buffer sized for full rate, no drops expected
no_overflow: assert property (@(posedge sys_clk) disable iff (!arst_n)
    !ovf)
    else $error("Packing buffer overflow");

endmodule

bind dptx_top dptx_tb_assertions u_assertions
(
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .msg_req    (msg_req),
    .msg_ack    (msg_ack),
    .msg_err    (msg_err),
    .ovf        (ovf)
);

`default_nettype wire

// ==== bench/dptx_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module dptx_tb;

localparam int P_LANES  = 4;
localparam int CLK_NS   = 100;
localparam int MSG_CYC  = 10;                 // Limit for one handshake phase
localparam int N_MAX    = 12;                 // Longest line in pixels
localparam int LINE_CYC = 4 * N_MAX + 40;     // Gaps up to 3 per pixel plus framing
localparam int N_MSGS   = 10;
localparam int N_LINES  = 4;
localparam int RUN_CYC  = 4 + N_MSGS * 2 * MSG_CYC + N_LINES * LINE_CYC + 16;
localparam int WATCHDOG_NS = (RUN_CYC + 200) * CLK_NS;

typedef dptx_pkg::sym_t [P_LANES-1:0] word_t;

localparam word_t FILL_WORD = {P_LANES{dptx_pkg::SYM_FILL}};
localparam word_t BS_WORD   = {P_LANES{dptx_pkg::SYM_BS}};
localparam word_t TPS1_WORD = {P_LANES{dptx_pkg::SYM_D10_2}};

logic               sys_clk;
logic               arst_n;
logic               msg_req;
dptx_pkg::msg_id_t  msg_id;
dptx_pkg::msg_dat_t msg_dat;
logic               msg_ack;
logic               msg_err;
logic               vid_cke;
logic               vid_de;
logic [7:0]         vid_r;
logic [7:0]         vid_g;
logic [7:0]         vid_b;
word_t              lnk_dat;
logic               ovf;

logic [31:0]        rng;            // xorshift state
logic [7:0]         exp_bytes [$];  // Line bytes in R, G, B order
word_t              got [$];        // Non-fill words seen on the link
logic               capture;

dptx_top #(.P_LANES(P_LANES)) u_dut
(
    .sys_clk    (sys_clk),
    .arst_n     (arst_n),
    .msg_req    (msg_req),
    .msg_id     (msg_id),
    .msg_dat    (msg_dat),
    .msg_ack    (msg_ack),
    .msg_err    (msg_err),
    .vid_cke    (vid_cke),
    .vid_de     (vid_de),
    .vid_r      (vid_r),
    .vid_g      (vid_g),
    .vid_b      (vid_b),
    .lnk_dat    (lnk_dat),
    .ovf        (ovf)
);

always #(CLK_NS / 2) sys_clk = ~sys_clk;

// Link monitor samples mid-period
always @(negedge sys_clk)
begin
    if (capture && lnk_dat != FILL_WORD)
        got.push_back(lnk_dat);
end

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1);
endtask

task automatic check_sym(input string name, input dptx_pkg::sym_t val, input dptx_pkg::sym_t exp);
    if (val !== exp)
        report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, val, exp));
endtask

task automatic check_bit(input string name, input logic val, input logic exp);
    if (val !== exp)
        report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, val, exp));
endtask

// Same symbol expected on every lane
task automatic check_lanes(input word_t w, input dptx_pkg::sym_t exp, input string what);
    for (int l = 0; l < P_LANES; l++)
        check_sym($sformatf("%s lnk_dat[%0d]", what, l), w[l], exp);
endtask

task automatic wait_ack(input logic level);
    int i;
    for (i = 0; i < MSG_CYC && msg_ack !== level; i++)
        @(negedge sys_clk);
    if (msg_ack !== level)
        report_failure($sformatf("msg_ack did not go to %0b in time", level));
endtask

// Full four-phase exchange
task automatic send_msg(input dptx_pkg::msg_id_t id, input dptx_pkg::msg_dat_t dat,
                        input logic exp_err);
    @(posedge sys_clk);
    msg_id  <= id;
    msg_dat <= dat;
    msg_req <= 1'b1;
    wait_ack(1'b1);
    check_bit("msg_err", msg_err, exp_err);
    @(posedge sys_clk);
    msg_req <= 1'b0;
    wait_ack(1'b0);
    check_bit("msg_err", msg_err, 1'b0);    // Cleared with ack
endtask

task automatic drive_line(input int n, input bit gaps);
    int gap;
    for (int p = 0; p < n; p++)
    begin
        rng = xorshift(rng);
        gap = gaps ? int'(rng[25:24]) : 0;
        repeat (gap)
        begin
            @(posedge sys_clk);
            vid_cke <= 1'b0;
        end
        @(posedge sys_clk);
        vid_cke <= 1'b1;
        vid_de  <= 1'b1;
        vid_r   <= rng[7:0];
        vid_g   <= rng[15:8];
        vid_b   <= rng[23:16];
        exp_bytes.push_back(rng[7:0]);
        exp_bytes.push_back(rng[15:8]);
        exp_bytes.push_back(rng[23:16]);
    end
    // Falling de releases the held last pixel
    repeat (2)
    begin
        @(posedge sys_clk);
        vid_cke <= 1'b1;
        vid_de  <= 1'b0;
    end
endtask

function automatic bit bs_seen();
    return (got.size() > 0) && (got[got.size()-1] == BS_WORD);
endfunction

task automatic wait_bs();
    for (int i = 0; i < LINE_CYC && !bs_seen(); i++)
        @(negedge sys_clk);
    if (!bs_seen())
        report_failure("No BS word appeared after the line");
endtask

// BE then data words with byte n on lane n mod P_LANES then BS
task automatic check_line();
    int             nwords;
    int             idx;
    dptx_pkg::sym_t exp;
    nwords = (exp_bytes.size() + P_LANES - 1) / P_LANES;
    if (got.size() != nwords + 2)
        report_failure($sformatf("Line gave %0d non-fill words, expected %0d",
                                 got.size(), nwords + 2));
    check_lanes(got[0], dptx_pkg::SYM_BE, "BE");
    for (int w = 0; w < nwords; w++)
    begin
        for (int l = 0; l < P_LANES; l++)
        begin
            idx = w * P_LANES + l;
            exp = (idx < exp_bytes.size()) ? {1'b0, exp_bytes[idx]} : '0;   // Zero pad
            check_sym($sformatf("word %0d lnk_dat[%0d]", w, l), got[w+1][l], exp);
        end
    end
    check_lanes(got[nwords+1], dptx_pkg::SYM_BS, "BS");
endtask

task automatic run_line(input int n, input bit gaps);
    exp_bytes.delete();
    got.delete();
    capture = 1'b1;
    drive_line(n, gaps);
    wait_bs();
    capture = 1'b0;
    check_line();
    check_bit("ovf", ovf, 1'b0);
endtask

task automatic test_reset();
    check_lanes(lnk_dat, '0, "reset");
    check_bit("msg_ack", msg_ack, 1'b0);
    check_bit("msg_err", msg_err, 1'b0);
    check_bit("ovf", ovf, 1'b0);
endtask

task automatic test_msg();
    send_msg(dptx_pkg::MSG_ID_CTL, 16'h0001, 1'b0);     // Link only
    check_lanes(lnk_dat, dptx_pkg::SYM_FILL, "link on");
    send_msg(8'h55, 16'h0000, 1'b1);                    // Unknown id
    check_lanes(lnk_dat, dptx_pkg::SYM_FILL, "after bad id");
    send_msg(dptx_pkg::MSG_ID_TPS, 16'h0000, 1'b0);
endtask

task automatic test_tps();
    dptx_pkg::sym_t exp;
    send_msg(dptx_pkg::MSG_ID_TPS, 16'h0001, 1'b0);
    check_lanes(lnk_dat, dptx_pkg::SYM_D10_2, "TPS1");
    got.delete();
    capture = 1'b1;     // Record the switch out of TPS1
    send_msg(dptx_pkg::MSG_ID_TPS, 16'h0002, 1'b0);
    repeat (8) @(negedge sys_clk);
    capture = 1'b0;
    while (got.size() > 0 && got[0] == TPS1_WORD)
        void'(got.pop_front());
    if (got.size() < 8)
        report_failure($sformatf("Only %0d TPS2 words seen on the link", got.size()));
    exp = dptx_pkg::SYM_K28_5;  // Pattern opens with K28.5
    for (int i = 0; i < got.size(); i++)
    begin
        check_lanes(got[i], exp, "TPS2");
        exp = (exp == dptx_pkg::SYM_K28_5) ? dptx_pkg::SYM_D11_6 : dptx_pkg::SYM_K28_5;
    end
    send_msg(dptx_pkg::MSG_ID_TPS, 16'h0000, 1'b0);
endtask

task automatic test_disable();
    send_msg(dptx_pkg::MSG_ID_CTL, 16'h0001, 1'b0);     // Video off
    exp_bytes.delete();
    got.delete();
    capture = 1'b1;
    drive_line(6, 1'b0);
    repeat (20) @(negedge sys_clk);
    capture = 1'b0;
    if (got.size() != 0)
        report_failure("Link showed non-fill symbols with video disabled");
    send_msg(dptx_pkg::MSG_ID_CTL, 16'h0000, 1'b0);     // Link off
    @(negedge sys_clk);
    check_lanes(lnk_dat, '0, "link off");
endtask

initial
begin
    #(WATCHDOG_NS);
    report_failure("Watchdog expired before the tests finished");
end

initial
begin
    sys_clk = 1'b0;
    arst_n  = 1'b0;
    msg_req = 1'b0;
    msg_id  = '0;
    msg_dat = '0;
    vid_cke = 1'b0;
    vid_de  = 1'b0;
    vid_r   = '0;
    vid_g   = '0;
    vid_b   = '0;
    rng     = 32'd25;
    capture = 1'b0;
    repeat (2) @(posedge sys_clk);
    arst_n <= 1'b1;
    @(negedge sys_clk);

    test_reset();
    test_msg();
    test_tps();
    send_msg(dptx_pkg::MSG_ID_CTL, 16'h0003, 1'b0);     // Video mode
    run_line(10, 1'b0);     // Single line of 30 bytes
    run_line(7, 1'b1);      // Gapped line with a padded last word
    run_line(N_MAX, 1'b1);  // Gapped line that fills its last word
    test_disable();

    $display("Everything OK");
    $finish;
end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/dptx_pkg.sv
rtl/dptx_vid_if.sv
rtl/dptx_word_if.sv
rtl/dptx_msg_rx.sv
rtl/dptx_vid_in.sv
rtl/dptx_packer.sv
rtl/dptx_lnk_gen.sv
rtl/dptx_top.sv
bench/dptx_tb_assertions.sv
bench/dptx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the DisplayPort TX testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module dptx_tb \
        -f sim.f -o dptx_sim; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/dptx_sim 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi

echo "Pass line not found"
exit 1
